//--- verilog/ttt_pkg.sv
// cells are numbered row-major 0..8; a row or column value of 3 is never a legal coordinate
package ttt_pkg;

    // board geometry
    localparam int GRID_DIM  = 3;
    localparam int NUM_CELLS = GRID_DIM * GRID_DIM;
    localparam int NUM_LINES = 2 * GRID_DIM + 2;

    typedef logic [1:0]             mark_t;
    typedef logic [1:0]             result_t;
    typedef logic [1:0]             coord_t;
    typedef logic [3:0]             cell_idx_t;
    typedef logic [2*NUM_CELLS-1:0] board_t;

    // cell contents and player marks
    localparam mark_t MARK_NONE = 2'b00;
    localparam mark_t MARK_O    = 2'b01;
    localparam mark_t MARK_X    = 2'b10;
    localparam mark_t MARK_BAD  = 2'b11;

    // game result, winner codes line up with the mark codes
    localparam result_t RES_PLAYING = 2'b00;
    localparam result_t RES_O_WIN   = 2'b01;
    localparam result_t RES_X_WIN   = 2'b10;
    localparam result_t RES_TIE     = 2'b11;

    localparam coord_t    COORD_BAD = 2'd3;
    localparam cell_idx_t LAST_CELL = cell_idx_t'(NUM_CELLS - 1);

    // rows, then columns, then the two diagonals
    localparam cell_idx_t WIN_LINES [NUM_LINES][3] = '{
        '{4'd0, 4'd1, 4'd2}, '{4'd3, 4'd4, 4'd5}, '{4'd6, 4'd7, 4'd8},
        '{4'd0, 4'd3, 4'd6}, '{4'd1, 4'd4, 4'd7}, '{4'd2, 4'd5, 4'd8},
        '{4'd0, 4'd4, 4'd8}, '{4'd2, 4'd4, 4'd6}
    };

    function automatic cell_idx_t cell_index(coord_t row, coord_t col);
        return cell_idx_t'(row * GRID_DIM + col);
    endfunction

    function automatic coord_t cell_row(cell_idx_t idx);
        return coord_t'(idx / GRID_DIM);
    endfunction

    function automatic coord_t cell_col(cell_idx_t idx);
        return coord_t'(idx % GRID_DIM);
    endfunction

    // indices past the last cell read as empty
    function automatic mark_t get_cell(board_t board, cell_idx_t idx);
        if (idx > LAST_CELL) begin
            return MARK_NONE;
        end
        return board[2*idx +: 2];
    endfunction

endpackage

//--- verilog/ai_playbook.sv
// plays X only and assumes X opened top-left; on a full board the suggestion is cell 0
module ai_playbook import ttt_pkg::*; (
    input  board_t cells,
    output coord_t ai_row,
    output coord_t ai_col
);

    // bit k set when cell k is empty
    logic [NUM_CELLS-1:0] empty;

    logic      o_centre;
    logic      o_edge;
    cell_idx_t first_empty;
    cell_idx_t pick;

    always_comb begin
        for (int k = 0; k < NUM_CELLS; k++) begin
            empty[k] = (get_cell(cells, cell_idx_t'(k)) == MARK_NONE);
        end
    end

    // O's reply decides the book
    assign o_centre = (get_cell(cells, 4'd4) == MARK_O);
    assign o_edge   = (get_cell(cells, 4'd3) == MARK_O) ||
                      (get_cell(cells, 4'd6) == MARK_O);

    // fallback so that an empty cell is always found
    always_comb begin
        first_empty = 4'd0;
        for (int k = NUM_CELLS - 1; k >= 0; k--) begin
            if (empty[k]) begin
                first_empty = cell_idx_t'(k);
            end
        end
    end

    // every pattern requires its own target cell to be empty
    always_comb begin
        if (o_centre) begin
            casez (empty)
                9'b????????1: pick = 4'd0;
                // opposite corner
                9'b1???????0: pick = 4'd8;
                // then the other two corners
                9'b0?????1?0: pick = 4'd2;
                9'b0?1???0?0: pick = 4'd6;
                default:      pick = first_empty;
            endcase
        end else if (o_edge) begin
            casez (empty)
                9'b????????1: pick = 4'd0;
                // top right
                9'b??????1?0: pick = 4'd2;
                // middle right
                9'b???1??0?0: pick = 4'd5;
                // lower two cells of the middle column
                9'b?1?0??0?0: pick = 4'd7;
                9'b?0?01?0?0: pick = 4'd4;
                default:      pick = first_empty;
            endcase
        end else begin
            casez (empty)
                9'b????????1: pick = 4'd0;
                // bottom left
                9'b??1?????0: pick = 4'd6;
                // middle right keeps the tie safe
                9'b??01????0: pick = 4'd5;
                // take a cell in the centre column
                9'b??001???0: pick = 4'd4;
                9'b??000??10: pick = 4'd1;
                9'b?1000??00: pick = 4'd7;
                default:      pick = first_empty;
            endcase
        end
    end

    assign ai_row = cell_row(pick);
    assign ai_col = cell_col(pick);

endmodule

//--- verilog/board_store.sv
// write_en must only rise for a legal empty cell; the store itself does not reject writes
module board_store import ttt_pkg::*; (
    input  logic   ph1,
    input  logic   reset,
    input  logic   write_en,
    input  coord_t write_row,
    input  coord_t write_col,
    input  mark_t  write_mark,
    output logic   cell_taken,
    output board_t cells
);

    cell_idx_t wr_idx;
    logic      addr_ok;

    // row-major cell number of the write port address
    assign wr_idx = cell_index(write_row, write_col);

    // coordinate 3 would alias onto a real cell, so mask it here
    assign addr_ok = (write_row != COORD_BAD) && (write_col != COORD_BAD);

    // occupancy lookup for the move checker
    assign cell_taken = addr_ok && (get_cell(cells, wr_idx) != MARK_NONE);

    // nine two-bit cells, one write per cycle
    always_ff @(posedge ph1) begin
        if (reset) begin
            cells <= '0;
        end else begin
            for (int k = 0; k < NUM_CELLS; k++) begin
                if (write_en && addr_ok && (wr_idx == cell_idx_t'(k))) begin
                    cells[2*k +: 2] <= write_mark;
                end
            end
        end
    end

endmodule

//--- verilog/cell_scanner.sv
// shows one cell per cycle in row-major order, so a full sweep of the board takes nine cycles
module cell_scanner import ttt_pkg::*; (
    input  logic   ph1,
    input  logic   reset,
    input  board_t cells,
    output mark_t  xoro_out,
    output coord_t row_out,
    output coord_t col_out
);

    cell_idx_t scan_idx;

    // 0..8 then wrap
    always_ff @(posedge ph1) begin
        if (reset) begin
            scan_idx <= '0;
        end else if (scan_idx == LAST_CELL) begin
            scan_idx <= '0;
        end else begin
            scan_idx <= scan_idx + 4'd1;
        end
    end

    // position and contents of the current cell
    assign row_out  = cell_row(scan_idx);
    assign col_out  = cell_col(scan_idx);
    assign xoro_out = get_cell(cells, scan_idx);

endmodule

//--- verilog/line_judge.sv
// assumes at most one player can hold a line; a board with lines for both reports X
module line_judge import ttt_pkg::*; (
    input  board_t  cells,
    output result_t result
);

    logic x_line;
    logic o_line;
    logic board_full;

    // mark that owns the whole line, or MARK_NONE
    function automatic mark_t line_owner(board_t board, int line);
        mark_t a;
        mark_t b;
        mark_t c;
        a = get_cell(board, WIN_LINES[line][0]);
        b = get_cell(board, WIN_LINES[line][1]);
        c = get_cell(board, WIN_LINES[line][2]);
        if ((a != MARK_NONE) && (a == b) && (b == c)) begin
            return a;
        end
        return MARK_NONE;
    endfunction

    always_comb begin
        x_line = 1'b0;
        o_line = 1'b0;
        for (int l = 0; l < NUM_LINES; l++) begin
            if (line_owner(cells, l) == MARK_X) begin
                x_line = 1'b1;
            end
            if (line_owner(cells, l) == MARK_O) begin
                o_line = 1'b1;
            end
        end
    end

    // tie needs every cell filled
    always_comb begin
        board_full = 1'b1;
        for (int k = 0; k < NUM_CELLS; k++) begin
            if (get_cell(cells, cell_idx_t'(k)) == MARK_NONE) begin
                board_full = 1'b0;
            end
        end
    end

    always_comb begin
        if (x_line) begin
            result = RES_X_WIN;
        end else if (o_line) begin
            result = RES_O_WIN;
        end else if (board_full) begin
            result = RES_TIE;
        end else begin
            result = RES_PLAYING;
        end
    end

endmodule

//--- verilog/move_checker.sv
// ai_en on X's turn takes the playbook cell and ignores row_in and col_in; bad requests are dropped
module move_checker import ttt_pkg::*; (
    input  logic    ph1,
    input  logic    reset,
    input  mark_t   xoro_in,
    input  coord_t  row_in,
    input  coord_t  col_in,
    input  logic    ai_en,
    input  coord_t  ai_row,
    input  coord_t  ai_col,
    input  result_t result,
    input  logic    cell_taken,
    output logic    err,
    output logic    write_en,
    output coord_t  write_row,
    output coord_t  write_col,
    output mark_t   write_mark
);

    // MARK_X or MARK_O for the player to move
    mark_t turn;

    logic request;
    logic use_ai;

    logic gameover_err;
    logic parse_err;
    logic turn_err;
    logic ai_turn_err;
    logic ai_mix_err;

    // any mark or an ai_en pulse counts as a move attempt
    assign request = (xoro_in != MARK_NONE) || ai_en;

    // playbook wins the write port only when X is to move
    assign use_ai     = ai_en && (turn == MARK_X);
    assign write_row  = use_ai ? ai_row : row_in;
    assign write_col  = use_ai ? ai_col : col_in;
    assign write_mark = use_ai ? MARK_X : xoro_in;

    assign gameover_err = (result != RES_PLAYING);

    // coordinates are checked after source selection
    assign parse_err = (write_row == COORD_BAD) || (write_col == COORD_BAD) ||
                       (xoro_in == MARK_BAD);

    assign turn_err    = (xoro_in != MARK_NONE) && (xoro_in != turn);
    assign ai_turn_err = ai_en && (turn == MARK_O);

    // an AI request must not carry a manual mark as well
    assign ai_mix_err = ai_en && (xoro_in != MARK_NONE);

    // cell_taken comes back from the board lookup for the selected cell
    assign err = request && (gameover_err || parse_err || turn_err ||
                             ai_turn_err || ai_mix_err || cell_taken);

    // no board write while reset is held
    assign write_en = request && !err && !reset;

    // turn flips only on an accepted move
    always_ff @(posedge ph1) begin
        if (reset) begin
            turn <= MARK_X;
        end else if (write_en) begin
            turn <= (turn == MARK_X) ? MARK_O : MARK_X;
        end
    end

endmodule

//--- verilog/tictactoe.sv
// one move request per cycle with no handshake; err is combinational on the move inputs
module tictactoe import ttt_pkg::*; (
    input  logic    ph1,
    input  logic    reset,
    input  mark_t   xoro_in,
    input  coord_t  row_in,
    input  coord_t  col_in,
    input  logic    ai_en,
    output logic    err,
    output mark_t   xoro_out,
    output coord_t  row_out,
    output coord_t  col_out,
    output result_t win
);

    // board write port driven by the move checker
    logic   write_en;
    coord_t write_row;
    coord_t write_col;
    mark_t  write_mark;
    logic   cell_taken;

    board_t cells;

    // playbook suggestion for X
    coord_t ai_row;
    coord_t ai_col;

    move_checker move_check (
        .ph1        (ph1),
        .reset      (reset),
        .xoro_in    (xoro_in),
        .row_in     (row_in),
        .col_in     (col_in),
        .ai_en      (ai_en),
        .ai_row     (ai_row),
        .ai_col     (ai_col),
        .result     (win),
        .cell_taken (cell_taken),
        .err        (err),
        .write_en   (write_en),
        .write_row  (write_row),
        .write_col  (write_col),
        .write_mark (write_mark)
    );

    board_store board (
        .ph1        (ph1),
        .reset      (reset),
        .write_en   (write_en),
        .write_row  (write_row),
        .write_col  (write_col),
        .write_mark (write_mark),
        .cell_taken (cell_taken),
        .cells      (cells)
    );

    line_judge judge (
        .cells  (cells),
        .result (win)
    );

    ai_playbook playbook (
        .cells  (cells),
        .ai_row (ai_row),
        .ai_col (ai_col)
    );

    cell_scanner scanner (
        .ph1      (ph1),
        .reset    (reset),
        .cells    (cells),
        .xoro_out (xoro_out),
        .row_out  (row_out),
        .col_out  (col_out)
    );

endmodule

//--- verif/tictactoe_chk.sv
// sampled on the rising edge of ph1; write_en is the board write enable inside the top level
module tictactoe_chk import ttt_pkg::*; (
    input logic   ph1,
    input logic   reset,
    input mark_t  xoro_in,
    input logic   ai_en,
    input logic   err,
    input coord_t row_out,
    input coord_t col_out,
    input logic   write_en
);

    // err only belongs to a move attempt
    no_request_no_err: assert property (@(posedge ph1) disable iff (reset)
        ((xoro_in == MARK_NONE) && !ai_en) |-> !err)
        else $error("err raised in a cycle with no move request");

    scan_coord_valid: assert property (@(posedge ph1) disable iff (reset)
        (row_out != COORD_BAD) && (col_out != COORD_BAD))
        else $error("scanner presented coordinate 3");

    // the board must not be written while reset is held
    no_write_in_reset: assert property (@(posedge ph1) reset |-> !write_en)
        else $error("board write enabled while reset is held");

endmodule

//--- verif/tictactoe_monitor.sv
// samples on the falling edge; the stimulus must stay idle while an AI move is traced on the scan
module tictactoe_monitor import ttt_pkg::*; (
    input  logic    ph1,
    input  logic    reset,
    input  mark_t   xoro_in,
    input  coord_t  row_in,
    input  coord_t  col_in,
    input  logic    ai_en,
    input  logic    err,
    input  mark_t   xoro_out,
    input  coord_t  row_out,
    input  coord_t  col_out,
    input  result_t win,
    output logic    ai_pending,
    output int      value_errors,
    output int      other_errors
);

    // model board in row-major order and whose move it is
    mark_t model [NUM_CELLS];
    mark_t turn;
    int    scan;

    // AI move trace over one full scan
    int    seen;
    int    new_x;
    int    found;
    logic  was_empty;

    initial begin
        value_errors = 0;
        other_errors = 0;
        ai_pending   = 1'b0;
        scan         = 0;
        turn         = MARK_X;
    end

    task automatic report(string name, int expected, int actual);
        $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
        value_errors++;
    endtask

    function automatic mark_t owner(int a, int b, int c);
        if ((model[a] != MARK_NONE) && (model[a] == model[b]) && (model[b] == model[c])) begin
            return model[a];
        end
        return MARK_NONE;
    endfunction

    // three in a line wins and otherwise a full board is a tie
    function automatic result_t model_result();
        mark_t w;
        logic  full;
        w = MARK_NONE;
        full = 1'b1;
        for (int i = 0; i < 3; i++) begin
            if (owner(3*i, 3*i + 1, 3*i + 2) != MARK_NONE) begin
                w = owner(3*i, 3*i + 1, 3*i + 2);
            end
            if (owner(i, i + 3, i + 6) != MARK_NONE) begin
                w = owner(i, i + 3, i + 6);
            end
        end
        if (owner(0, 4, 8) != MARK_NONE) begin
            w = owner(0, 4, 8);
        end
        if (owner(2, 4, 6) != MARK_NONE) begin
            w = owner(2, 4, 6);
        end
        for (int k = 0; k < NUM_CELLS; k++) begin
            if (model[k] == MARK_NONE) begin
                full = 1'b0;
            end
        end
        if (w == MARK_X) begin
            return RES_X_WIN;
        end
        if (w == MARK_O) begin
            return RES_O_WIN;
        end
        return full ? RES_TIE : RES_PLAYING;
    endfunction

    always @(negedge ph1) begin
        logic request;
        logic taken;
        logic exp_err;
        int   target;
        request = (xoro_in != MARK_NONE) || ai_en;
        target = 3 * row_in + col_in;
        if (reset) begin
            for (int k = 0; k < NUM_CELLS; k++) begin
                model[k] = MARK_NONE;
            end
            turn = MARK_X;
            scan = 0;
            ai_pending = 1'b0;
        end else begin
            if (row_out !== coord_t'(scan / 3)) begin
                report("row_out", scan / 3, row_out);
            end
            if (col_out !== coord_t'(scan % 3)) begin
                report("col_out", scan % 3, col_out);
            end
            if (ai_pending) begin
                if (request) begin
                    $display("a move request arrived while an AI move was still being traced");
                    other_errors++;
                end
                if ((model[scan] == MARK_NONE) && (xoro_out == MARK_X)) begin
                    new_x++;
                    found = scan;
                end else if (xoro_out !== model[scan]) begin
                    report("xoro_out", model[scan], xoro_out);
                end
                seen++;
                if (seen == NUM_CELLS) begin
                    ai_pending = 1'b0;
                    if (new_x != 1) begin
                        $display("the AI move placed %0d new X marks instead of one", new_x);
                        other_errors++;
                    end else begin
                        // opening move goes top-left
                        if (was_empty && (found != 0)) begin
                            report("ai_cell", 0, found);
                        end
                        model[found] = MARK_X;
                    end
                end
            end else begin
                if (xoro_out !== model[scan]) begin
                    report("xoro_out", model[scan], xoro_out);
                end
                if (win !== model_result()) begin
                    report("win", model_result(), win);
                end
                taken = 1'b0;
                if ((row_in != COORD_BAD) && (col_in != COORD_BAD)) begin
                    taken = (model[target] != MARK_NONE);
                end
                exp_err = request && ((model_result() != RES_PLAYING) || (xoro_in == MARK_BAD) ||
                          (ai_en && ((turn == MARK_O) || (xoro_in != MARK_NONE))) ||
                          (!ai_en && ((row_in == COORD_BAD) || (col_in == COORD_BAD) ||
                                      (xoro_in != turn) || taken)));
                if (err !== exp_err) begin
                    report("err", exp_err, err);
                end
                if (request && !exp_err) begin
                    if (ai_en) begin
                        // cell is unknown until the scan has shown every cell
                        ai_pending = 1'b1;
                        seen = 0;
                        new_x = 0;
                        was_empty = 1'b1;
                        for (int k = 0; k < NUM_CELLS; k++) begin
                            if (model[k] != MARK_NONE) begin
                                was_empty = 1'b0;
                            end
                        end
                    end else begin
                        model[target] = xoro_in;
                    end
                    turn = (turn == MARK_X) ? MARK_O : MARK_X;
                end
            end
            scan = (scan + 1) % NUM_CELLS;
        end
    end

endmodule

//--- verif/tictactoe_tb.sv
// plays 40 random games from xorshift seed 29; inputs stay idle while an AI move is traced
module tictactoe_tb import ttt_pkg::*; ();

    localparam int GAMES      = 40;
    localparam int GAME_LIMIT = 200;
    localparam int AI_LIMIT   = 20;

    logic        ph1;
    logic        reset;
    mark_t       xoro_in;
    coord_t      row_in;
    coord_t      col_in;
    logic        ai_en;
    logic        err;
    mark_t       xoro_out;
    coord_t      row_out;
    coord_t      col_out;
    result_t     win;
    logic        ai_pending;
    int          value_errors;
    int          other_errors;
    int          timeouts;
    logic [31:0] rng;

    tictactoe tictactoe_inst (
        .ph1      (ph1),
        .reset    (reset),
        .xoro_in  (xoro_in),
        .row_in   (row_in),
        .col_in   (col_in),
        .ai_en    (ai_en),
        .err      (err),
        .xoro_out (xoro_out),
        .row_out  (row_out),
        .col_out  (col_out),
        .win      (win)
    );

    tictactoe_monitor monitor (
        .ph1          (ph1),
        .reset        (reset),
        .xoro_in      (xoro_in),
        .row_in       (row_in),
        .col_in       (col_in),
        .ai_en        (ai_en),
        .err          (err),
        .xoro_out     (xoro_out),
        .row_out      (row_out),
        .col_out      (col_out),
        .win          (win),
        .ai_pending   (ai_pending),
        .value_errors (value_errors),
        .other_errors (other_errors)
    );

    bind tictactoe tictactoe_chk chk (
        .ph1      (ph1),
        .reset    (reset),
        .xoro_in  (xoro_in),
        .ai_en    (ai_en),
        .err      (err),
        .row_out  (row_out),
        .col_out  (col_out),
        .write_en (write_en)
    );

    always #2 ph1 = ~ph1;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic drive_idle();
        @(posedge ph1);
        xoro_in <= MARK_NONE;
        row_in  <= 2'd0;
        col_in  <= 2'd0;
        ai_en   <= 1'b0;
    endtask

    // mostly plausible moves, some bad codes, some AI requests and idle cycles
    task automatic drive_random();
        int     kind;
        int     waited;
        mark_t  m;
        coord_t r;
        coord_t c;
        logic   a;
        @(posedge ph1);
        rng = xorshift(rng);
        kind = rng % 16;
        m = rng[4] ? MARK_X : MARK_O;
        r = coord_t'(rng[11:8] % 3);
        c = coord_t'(rng[15:12] % 3);
        a = 1'b0;
        if (kind >= 13) begin
            m = MARK_NONE;
        end else if (kind >= 10) begin
            a = 1'b1;
            m = ((kind == 12) && rng[20]) ? MARK_X : MARK_NONE;
        end else if (kind == 9) begin
            case (rng[21:20])
                2'd0: r = COORD_BAD;
                2'd1: c = COORD_BAD;
                2'd2: m = MARK_BAD;
                default: begin
                    r = COORD_BAD;
                    c = COORD_BAD;
                end
            endcase
        end
        xoro_in <= m;
        row_in  <= r;
        col_in  <= c;
        ai_en   <= a;
        if (a) begin
            drive_idle();
            waited = 0;
            while (ai_pending && (waited < AI_LIMIT)) begin
                drive_idle();
                waited++;
            end
            if (ai_pending) begin
                $display("timeout: AI move did not show up on the scan within %0d cycles", AI_LIMIT);
                timeouts++;
            end
        end
    endtask

    task automatic pulse_reset();
        @(posedge ph1);
        reset   <= 1'b1;
        xoro_in <= MARK_NONE;
        ai_en   <= 1'b0;
        // X moves while reset is held must not reach the board
        repeat (15) begin
            @(posedge ph1);
            rng = xorshift(rng);
            xoro_in <= rng[4] ? MARK_X : MARK_NONE;
            row_in  <= coord_t'(rng[11:8] % 3);
            col_in  <= coord_t'(rng[15:12] % 3);
        end
        @(posedge ph1);
        reset   <= 1'b0;
        xoro_in <= MARK_NONE;
    endtask

    task automatic play_game();
        int   cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        while (!done && (cycles < GAME_LIMIT)) begin
            drive_random();
            @(negedge ph1);
            done = (win != RES_PLAYING);
            cycles++;
        end
        // late requests must all be rejected
        for (int i = 0; i < 6; i++) begin
            drive_random();
        end
    endtask

    initial begin
        ph1      = 1'b0;
        reset    = 1'b1;
        xoro_in  = MARK_NONE;
        row_in   = 2'd0;
        col_in   = 2'd0;
        ai_en    = 1'b0;
        rng      = 32'd29;
        timeouts = 0;
        for (int g = 0; g < GAMES; g++) begin
            pulse_reset();
            play_game();
        end
        drive_idle();
        repeat (2) @(posedge ph1);
        $display("errors: value=%0d other=%0d timeouts=%0d", value_errors, other_errors, timeouts);
        if ((value_errors + other_errors + timeouts) == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
verilog/ttt_pkg.sv
verilog/ai_playbook.sv
verilog/board_store.sv
verilog/cell_scanner.sv
verilog/line_judge.sv
verilog/move_checker.sv
verilog/tictactoe.sv
verif/tictactoe_chk.sv
verif/tictactoe_monitor.sv
verif/tictactoe_tb.sv

//--- Makefile
# Verilator 5 with --timing is needed for the testbench clock
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tictactoe_tb
RTL_TOP    := tictactoe
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := *** TEST FAILED ***
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# a missing pass line also counts as failure, e.g. after an assertion stop
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -F -q '$(FAIL_MSG)' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -F -q '$(PASS_MSG)' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
